// File: include/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Address and instruction word width
`define FETCH_ADDR_W 32

// Direct-mapped instruction cache geometry
`define ICACHE_LINES 8
`define ICACHE_LINE_WORDS 4
`define ICACHE_IDX_W ($clog2(`ICACHE_LINES))
`define ICACHE_OFS_W ($clog2(`ICACHE_LINE_WORDS))

// Bits left for the tag after index, word offset and byte offset
`define ICACHE_TAG_W (`FETCH_ADDR_W - `ICACHE_IDX_W - `ICACHE_OFS_W - 2)

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

// File: run.sh
#!/usr/bin/env bash
# Build and run the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module fetch_tb -f sources.f \
    --Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/fetch_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

// File: sim/axi_rd_mem.sv
module axi_rd_mem import fetch_mem_pkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  axi_ar_t ar_i,
    output logic    arready_o,
    output axi_r_t  r_o,
    input  logic    rready_i
);

    integer      seed;
    logic        busy_q;
    logic [31:0] addr_q;
    int          delay_q;

    // Same address rule as the testbench reference
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [24:0] fold;
        fold = addr[31:7] ^ {5'b0, addr[21:2]};
        case (addr)
            32'h7c, 32'h21c, 32'h33c, 32'h51c: mem_word = {fold, 7'b1101111};
            default:                           mem_word = {fold, 7'b0010011};
        endcase
    endfunction

    initial seed = 32'h358ed704;

    // One read at a time, data after a random wait of 0 to 7 cycles
    always @(posedge clk_i) begin
        if (rst_i) begin
            arready_o <= 1'b1;
            busy_q    <= 1'b0;
            r_o       <= '0;
            delay_q   <= 0;
        end else if (ar_i.arvalid && arready_o) begin
            arready_o <= 1'b0;
            busy_q    <= 1'b1;
            addr_q    <= ar_i.araddr;
            delay_q   <= $random(seed) & 7;
        end else if (busy_q && !r_o.rvalid) begin
            if (delay_q == 0) begin
                r_o.rvalid <= 1'b1;
                r_o.rdata  <= mem_word(addr_q);
                r_o.rresp  <= 2'b00;
            end else begin
                delay_q <= delay_q - 1;
            end
        end else if (r_o.rvalid && rready_i) begin
            r_o.rvalid <= 1'b0;
            busy_q     <= 1'b0;
            arready_o  <= 1'b1;
        end
    end

endmodule

// File: sim/fetch_tb.sv
`include "fetch_params.svh"

module fetch_tb import fetch_pkg::*, fetch_mem_pkg::*; ();

    // Six runs of at most 32 words with every miss under 50 cycles
    localparam int MAX_CYCLES = 20000;

    logic        clk_i;
    logic        rst_i;
    logic        stall_i;
    redirect_t   redirect_i;
    fetch_out_t  fetch_o;
    axi_ar_t     ar_o;
    logic        arready;
    axi_r_t      r;
    logic        rready;

    integer      seed;
    int          cycles;
    int          errors;
    int          tests_run;
    int          tests_passed;
    int          test_err_start;
    int          accepted;
    int          expected_total;
    int          ar_count;
    int          ar_mark;
    logic [31:0] ar_lo;
    logic [31:0] ar_hi;
    logic [31:0] exp_q [$];
    string       cur_test;

    fetch_stage i_fetch_stage (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .stall_i    (stall_i),
        .redirect_i (redirect_i),
        .fetch_o    (fetch_o),
        .ar_o       (ar_o),
        .arready_i  (arready),
        .r_i        (r),
        .rready_o   (rready)
    );

    axi_rd_mem i_axi_rd_mem (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .ar_i      (ar_o),
        .arready_o (arready),
        .r_o       (r),
        .rready_i  (rready)
    );

    // OP-IMM words with the address folded in and a JAL closing each run
    function automatic logic [31:0] expected_word(input logic [31:0] addr);
        logic [24:0] fold;
        fold = addr[31:7] ^ {5'b0, addr[21:2]};
        if (addr == 32'h7c || addr == 32'h21c || addr == 32'h33c || addr == 32'h51c) begin
            expected_word = {fold, 7'b1101111};
        end else begin
            expected_word = {fold, 7'b0010011};
        end
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("Fail %s %s: expected %h actual %h", cur_test, what, exp, act);
        errors++;
    endtask

    task automatic report_problem(input string msg);
        $display("Error in %s: %s", cur_test, msg);
        errors++;
    endtask

    task automatic start_test(input string name);
        cur_test       = name;
        test_err_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (exp_q.size() != 0) begin
            report_problem("expected instructions never arrived");
        end
        if (errors == test_err_start) begin
            tests_passed++;
            $display("test %s: passed", cur_test);
        end else begin
            $display("test %s: failed", cur_test);
        end
    endtask

    task automatic expect_run(input logic [31:0] start, input int count);
        for (int i = 0; i < count; i++) begin
            exp_q.push_back(start + 32'(4 * i));
        end
        expected_total += count;
    endtask

    task automatic wait_accepted();
        while (accepted < expected_total) begin
            @(negedge clk_i);
        end
    endtask

    task automatic send_redirect(input logic [31:0] target);
        redirect_i.valid  = 1'b1;
        redirect_i.target = target;
        @(negedge clk_i);
        redirect_i.valid = 1'b0;
    endtask

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    // Compare every accepted output and watch the AR channel
    always @(posedge clk_i) begin
        logic [31:0] exp_pc;
        if (!rst_i) begin
            if (fetch_o.valid && !stall_i) begin
                accepted++;
                if (exp_q.size() == 0) begin
                    report_problem("a valid output appeared when none was expected");
                end else begin
                    exp_pc = exp_q.pop_front();
                    if (fetch_o.pc != exp_pc) begin
                        report_mismatch("pc", exp_pc, fetch_o.pc);
                    end
                    if (fetch_o.instr.raw != expected_word(exp_pc)) begin
                        report_mismatch("instr", expected_word(exp_pc), fetch_o.instr.raw);
                    end
                end
            end
            if (ar_o.arvalid && arready) begin
                ar_count++;
                if (ar_o.araddr[1:0] != 2'b00) begin
                    report_problem("read address is not word aligned");
                end
                if (ar_o.araddr < ar_lo || ar_o.araddr >= ar_hi) begin
                    report_mismatch("araddr range start", ar_lo, ar_o.araddr);
                end
            end
        end
    end

    initial begin
        seed           = 32'h358ed704;
        rst_i          = 1'b1;
        stall_i        = 1'b0;
        redirect_i     = '0;
        cycles         = 0;
        errors         = 0;
        tests_run      = 0;
        tests_passed   = 0;
        accepted       = 0;
        expected_total = 0;
        ar_count       = 0;
        ar_lo          = 32'h0;
        ar_hi          = 32'h80;
        cur_test       = "reset";
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        start_test("reset");
        if (fetch_o.valid !== 1'b0 || ar_o.arvalid !== 1'b0 || rready !== 1'b0) begin
            report_problem("valid, arvalid or rready high right after reset");
        end
        exp_q.push_back(`FETCH_RESET_PC);
        expected_total = 1;
        wait_accepted();
        end_test();

        start_test("straight_run");
        expect_run(32'h4, 31);
        wait_accepted();
        end_test();

        // Every word of the loop is already cached
        start_test("cached_loop");
        ar_hi   = ar_lo;
        ar_mark = ar_count;
        expect_run(32'h0, 32);
        send_redirect(32'h0);
        wait_accepted();
        if (ar_count != ar_mark) begin
            report_problem("the AR channel was used although every word hits");
        end
        end_test();

        start_test("jal_wait");
        repeat (10) begin
            @(negedge clk_i);
            if (fetch_o.valid) begin
                report_problem("valid output while waiting for a redirect");
            end
        end
        ar_lo = 32'h200;
        ar_hi = 32'h220;
        expect_run(32'h200, 8);
        send_redirect(32'h200);
        wait_accepted();
        end_test();

        start_test("random_stall");
        ar_lo = 32'h300;
        ar_hi = 32'h340;
        expect_run(32'h300, 16);
        send_redirect(32'h300);
        while (accepted < expected_total) begin
            stall_i = (($random(seed) & 3) == 0);
            @(negedge clk_i);
        end
        stall_i = 1'b0;
        end_test();

        // Second redirect lands while the line at 0x400 is refilling
        start_test("redirect_in_refill");
        ar_lo = 32'h400;
        ar_hi = 32'h520;
        expect_run(32'h500, 8);
        send_redirect(32'h400);
        while (!ar_o.arvalid) begin
            @(negedge clk_i);
        end
        send_redirect(32'h500);
        wait_accepted();
        repeat (10) @(negedge clk_i);
        end_test();

        $display("tests run %0d, passed %0d, failed checks %0d",
                 tests_run, tests_passed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: source/fetch_fsm.sv
module fetch_fsm import fetch_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         stall_i,
    input  logic         hit_i,
    input  logic         refill_done_i,
    input  redirect_t    redirect_i,
    input  instr_u       out_instr_i,
    output logic         refill_start_o,
    output logic         pc_advance_o,
    output logic         out_load_o,
    output logic         out_valid_o,
    output fetch_state_e state_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;
    logic         is_ctrl;

    // Control transfer opcodes stop the fetch until the back end redirects
    always_comb begin
        case (out_instr_i.f.opcode)
            OP_BRANCH, OP_JAL, OP_JALR: is_ctrl = 1'b1;
            default:                    is_ctrl = 1'b0;
        endcase
    end

    always_comb begin
        state_d        = state_q;
        refill_start_o = 1'b0;
        pc_advance_o   = 1'b0;
        out_valid_o    = 1'b0;
        // Output register moves whenever decode takes it
        out_load_o     = !stall_i;

        case (state_q)
            LOOKUP: begin
                if (redirect_i.valid) begin
                    // Word at the old PC is dropped
                    state_d = LOOKUP;
                end else if (!hit_i) begin
                    refill_start_o = 1'b1;
                    state_d        = REFILL;
                end else if (!stall_i) begin
                    out_valid_o  = 1'b1;
                    pc_advance_o = 1'b1;
                    if (is_ctrl) begin
                        state_d = BRANCH_WAIT;
                    end
                end
            end
            REFILL: begin
                if (refill_done_i) begin
                    state_d = LOOKUP;
                end
            end
            BRANCH_WAIT: begin
                if (redirect_i.valid) begin
                    state_d = LOOKUP;
                end
            end
            default: begin
                state_d = LOOKUP;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= LOOKUP;
        end else begin
            state_q <= state_d;
        end
    end

    assign state_o = state_q;

    // Refill engine only finishes while the FSM waits in REFILL
    a_done_in_refill: assert property (@(posedge clk_i) disable iff (rst_i)
        refill_done_i |-> state_q == REFILL);

endmodule

// File: source/fetch_mem_pkg.sv
`include "fetch_params.svh"

package fetch_mem_pkg;

    // AXI4-Lite read address channel, master to slave
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] araddr;
        logic                     arvalid;
    } axi_ar_t;

    // AXI4-Lite read data channel, slave to master
    typedef struct packed {
        logic [`FETCH_ADDR_W-1:0] rdata;
        logic [1:0]               rresp;
        logic                     rvalid;
    } axi_r_t;

    // Fetch address as seen by the cache
    typedef struct packed {
        logic [`ICACHE_TAG_W-1:0] tag;
        logic [`ICACHE_IDX_W-1:0] index;
        logic [`ICACHE_OFS_W-1:0] offset;
        logic [1:0]               byte_ofs;
    } cache_addr_t;

    // One refill word written into the arrays
    typedef struct packed {
        logic                     we;
        logic [`ICACHE_IDX_W-1:0] index;
        logic [`ICACHE_OFS_W-1:0] offset;
        logic [`FETCH_ADDR_W-1:0] data;
        logic                     last;
    } cache_fill_t;

endpackage

// File: source/fetch_pc.sv
`include "fetch_params.svh"

module fetch_pc import fetch_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     advance_i,
    input  redirect_t                redirect_i,
    input  logic                     apply_i,
    output logic [`FETCH_ADDR_W-1:0] pc_o
);

    logic [`FETCH_ADDR_W-1:0] pc_q;
    logic                     pend_q;
    logic [`FETCH_ADDR_W-1:0] pend_target_q;
    logic [`FETCH_ADDR_W-1:0] target;

    // A fresh redirect wins over one still waiting
    assign target = redirect_i.valid ? redirect_i.target : pend_target_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pc_q   <= `FETCH_RESET_PC;
            pend_q <= 1'b0;
        end else if (apply_i && (redirect_i.valid || pend_q)) begin
            pc_q   <= target;
            pend_q <= 1'b0;
        end else begin
            if (redirect_i.valid) begin
                pend_q <= 1'b1;
            end
            if (advance_i) begin
                pc_q <= pc_q + `FETCH_ADDR_W'(4);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (redirect_i.valid) begin
            pend_target_q <= redirect_i.target;
        end
    end

    assign pc_o = pc_q;

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
        pc_q[1:0] == 2'b00);

endmodule

// File: source/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

    // Base RV32 instruction fields
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

    typedef union packed {
        logic [`FETCH_ADDR_W-1:0] raw;
        instr_fields_t            f;
    } instr_u;

    // Registered handoff to decode
    typedef struct packed {
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] pc;
        instr_u                   instr;
    } fetch_out_t;

    typedef enum logic [1:0] {
        LOOKUP,
        REFILL,
        BRANCH_WAIT
    } fetch_state_e;

    typedef struct packed {
        logic                     valid;
        logic [`FETCH_ADDR_W-1:0] target;
    } redirect_t;

    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

endpackage

// File: source/fetch_stage.sv
`include "fetch_params.svh"

module fetch_stage import fetch_pkg::*, fetch_mem_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_i,

    // Decode side
    input  logic       stall_i,
    input  redirect_t  redirect_i,
    output fetch_out_t fetch_o,

    // Refill port
    output axi_ar_t    ar_o,
    input  logic       arready_i,
    input  axi_r_t     r_i,
    output logic       rready_o
);

    logic [`FETCH_ADDR_W-1:0] pc;
    logic                     hit;
    instr_u                   word;
    cache_fill_t              fill;
    logic                     refill_start;
    logic                     refill_done;
    logic                     pc_advance;
    logic                     pc_apply;
    logic                     out_load;
    logic                     out_valid;
    fetch_state_e             state;

    logic                     out_valid_q;
    logic [`FETCH_ADDR_W-1:0] out_pc_q;
    instr_u                   out_instr_q;

    // Redirects wait out a refill, then land on the edge it completes
    assign pc_apply = (state != REFILL) || refill_done;

    fetch_fsm i_fetch_fsm (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .stall_i        (stall_i),
        .hit_i          (hit),
        .refill_done_i  (refill_done),
        .redirect_i     (redirect_i),
        .out_instr_i    (word),
        .refill_start_o (refill_start),
        .pc_advance_o   (pc_advance),
        .out_load_o     (out_load),
        .out_valid_o    (out_valid),
        .state_o        (state)
    );

    fetch_pc i_fetch_pc (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .advance_i  (pc_advance),
        .redirect_i (redirect_i),
        .apply_i    (pc_apply),
        .pc_o       (pc)
    );

    icache_tag i_icache_tag (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .pc_i   (pc),
        .fill_i (fill),
        .hit_o  (hit)
    );

    icache_data i_icache_data (
        .clk_i  (clk_i),
        .pc_i   (pc),
        .fill_i (fill),
        .word_o (word)
    );

    icache_refill i_icache_refill (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .start_i     (refill_start),
        .line_addr_i (pc),
        .ar_o        (ar_o),
        .arready_i   (arready_i),
        .r_i         (r_i),
        .rready_o    (rready_o),
        .fill_o      (fill),
        .done_o      (refill_done)
    );

    // Output register to decode
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_valid_q <= 1'b0;
        end else if (out_load) begin
            out_valid_q <= out_valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (out_load && out_valid) begin
            out_pc_q    <= pc;
            out_instr_q <= word;
        end
    end

    assign fetch_o.valid = out_valid_q;
    assign fetch_o.pc    = out_pc_q;
    assign fetch_o.instr = out_instr_q;

endmodule

// File: source/icache_data.sv
`include "fetch_params.svh"

module icache_data import fetch_pkg::*, fetch_mem_pkg::*; (
    input  logic                     clk_i,
    input  logic [`FETCH_ADDR_W-1:0] pc_i,
    input  cache_fill_t              fill_i,
    output instr_u                   word_o
);

    logic [`FETCH_ADDR_W-1:0] mem_q [`ICACHE_LINES][`ICACHE_LINE_WORDS];
    cache_addr_t              addr;

    assign addr = pc_i;

    always_ff @(posedge clk_i) begin
        if (fill_i.we) begin
            mem_q[fill_i.index][fill_i.offset] <= fill_i.data;
        end
    end

    // Asynchronous read, same cycle as the tag compare
    assign word_o.raw = mem_q[addr.index][addr.offset];

endmodule

// File: source/icache_refill.sv
`include "fetch_params.svh"

module icache_refill import fetch_mem_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic                     start_i,
    input  logic [`FETCH_ADDR_W-1:0] line_addr_i,
    output axi_ar_t                  ar_o,
    input  logic                     arready_i,
    input  axi_r_t                   r_i,
    output logic                     rready_o,
    output cache_fill_t              fill_o,
    output logic                     done_o
);

    logic                     busy_q;
    logic                     arvalid_q;
    logic [`ICACHE_OFS_W-1:0] ofs_q;
    cache_addr_t              line_q;
    cache_addr_t              word_addr;
    logic                     ar_fire;
    logic                     r_fire;
    logic                     last_word;

    // Word address inside the latched line
    always_comb begin
        word_addr          = line_q;
        word_addr.offset   = ofs_q;
        word_addr.byte_ofs = 2'b00;
    end

    assign ar_o.araddr  = word_addr;
    assign ar_o.arvalid = arvalid_q;

    // Data is accepted only once the address has gone out
    assign rready_o  = busy_q && !arvalid_q;
    assign ar_fire   = arvalid_q && arready_i;
    assign r_fire    = r_i.rvalid && rready_o;
    assign last_word = (ofs_q == `ICACHE_OFS_W'(`ICACHE_LINE_WORDS - 1));

    assign fill_o.we     = r_fire;
    assign fill_o.index  = word_addr.index;
    assign fill_o.offset = ofs_q;
    assign fill_o.data   = r_i.rdata;
    assign fill_o.last   = last_word;

    assign done_o = r_fire && last_word;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q    <= 1'b0;
            arvalid_q <= 1'b0;
            ofs_q     <= '0;
        end else if (start_i) begin
            busy_q    <= 1'b1;
            arvalid_q <= 1'b1;
            ofs_q     <= '0;
        end else if (ar_fire) begin
            arvalid_q <= 1'b0;
        end else if (r_fire) begin
            ofs_q <= ofs_q + 1'b1;
            if (last_word) begin
                busy_q <= 1'b0;
            end else begin
                arvalid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            line_q <= line_addr_i;
        end
    end

    a_no_start_busy: assert property (@(posedge clk_i) disable iff (rst_i)
        start_i |-> !busy_q);

    a_ar_stable: assert property (@(posedge clk_i) disable iff (rst_i)
        ar_o.arvalid && !arready_i |=> ar_o.arvalid && $stable(ar_o.araddr));

    // No fault path, an error response is only reported
    a_rresp_okay: assert property (@(posedge clk_i) disable iff (rst_i)
        r_fire |-> r_i.rresp == 2'b00)
        else $warning("refill read returned rresp %0d", r_i.rresp);

endmodule

// File: source/icache_tag.sv
`include "fetch_params.svh"

module icache_tag import fetch_mem_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic [`FETCH_ADDR_W-1:0] pc_i,
    input  cache_fill_t              fill_i,
    output logic                     hit_o
);

    logic [`ICACHE_LINES-1:0] valid_q;
    logic [`ICACHE_TAG_W-1:0] tag_q [`ICACHE_LINES];
    cache_addr_t              addr;

    assign addr = pc_i;

    assign hit_o = valid_q[addr.index] && (tag_q[addr.index] == addr.tag);

    // Line goes invalid on its first fill word, valid again on the last
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= '0;
        end else if (fill_i.we) begin
            valid_q[fill_i.index] <= fill_i.last;
        end
    end

    // PC still points at the missing line when the last word arrives
    always_ff @(posedge clk_i) begin
        if (fill_i.we && fill_i.last) begin
            tag_q[fill_i.index] <= addr.tag;
        end
    end

endmodule

// File: sources.f
+incdir+include
source/fetch_pkg.sv
source/fetch_mem_pkg.sv
source/fetch_fsm.sv
source/fetch_pc.sv
source/icache_tag.sv
source/icache_data.sv
source/icache_refill.sv
source/fetch_stage.sv
sim/axi_rd_mem.sv
sim/fetch_tb.sv
